/* common/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// core side address and data
`define MEM_ADDR_W        32
`define MEM_WORD_W        32

// one cache line, four words
`define MEM_LINE_W        128

// direct-mapped cache size in lines
`define CACHE_LINES       64

// backing memory
`define BACK_DEPTH_LINES  256
`define BACK_LAT          4   // stall cycles per access

`endif

/* common/mem_pkg.sv */
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } acc_size_e;

    // words for lane placement, bytes for masked merging
    typedef union packed {
        logic [`MEM_LINE_W/`MEM_WORD_W-1:0][`MEM_WORD_W-1:0] words;
        logic [`MEM_LINE_W/8-1:0][7:0]                      bytes;
    } line_u;

    typedef struct packed {
        logic                     rd;
        logic                     wr;
        logic [`MEM_ADDR_W-1:0]   addr;
        logic [`MEM_WORD_W-1:0]   wdata;
        logic [`MEM_WORD_W/8-1:0] be;
    } mem_req_t;

    typedef struct packed {
        logic                     rd;
        logic                     wr;
        logic [`MEM_ADDR_W-1:0]   addr;
        logic [`MEM_WORD_W-1:0]   wdata;   // already replicated by size
        logic [`MEM_WORD_W/8-1:0] be;
    } core_req_t;

    typedef struct packed {
        logic                   we;
        logic [`MEM_ADDR_W-1:0] addr;
        line_u                  line;
    } cache_wr_t;

endpackage

`default_nettype wire

/* logic/mem_req_front.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_req_front (
    input  wire                     CLK,
    input  wire                     i_rrst_x,
    input  wire                     i_rd_en,
    input  wire                     i_wr_en,
    input  wire [`MEM_ADDR_W-1:0]   i_addr,
    input  wire [`MEM_WORD_W-1:0]   i_wdata,
    input  wire mem_pkg::acc_size_e i_size,
    input  wire                     i_ctrl_busy,
    output mem_pkg::core_req_t      o_req,
    output wire                     o_busy
);

    logic                     r_rd;
    logic                     r_wr;
    logic [`MEM_ADDR_W-1:0]   r_addr;
    logic [`MEM_WORD_W-1:0]   r_wdata;
    logic [`MEM_WORD_W/8-1:0] r_be;
    logic                     w_accept;
    logic [`MEM_WORD_W/8-1:0] w_be;
    logic [`MEM_WORD_W-1:0]   w_wdata;

    assign w_accept = (i_rd_en | i_wr_en) & ~o_busy;

    // size and low address bits to lane mask
    always_comb begin
        case (i_size)
            mem_pkg::SZ_BYTE: begin
                w_be    = 4'b0001 << i_addr[1:0];
                w_wdata = {4{i_wdata[7:0]}};
            end
            mem_pkg::SZ_HALF: begin
                w_be    = 4'b0011 << {i_addr[1], 1'b0};
                w_wdata = {2{i_wdata[15:0]}};
            end
            default: begin
                w_be    = 4'b1111;
                w_wdata = i_wdata;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_rd <= 1'b0;
            r_wr <= 1'b0;
        end else begin
            r_rd <= i_rd_en & ~o_busy;   // one-cycle strobes
            r_wr <= i_wr_en & ~o_busy;
        end
    end

    always_ff @(posedge CLK) begin
        if (w_accept) begin
            r_addr  <= i_addr;
            r_wdata <= w_wdata;
            r_be    <= w_be;
        end
    end

    assign o_req.rd    = r_rd;
    assign o_req.wr    = r_wr;
    assign o_req.addr  = r_addr;
    assign o_req.wdata = r_wdata;
    assign o_req.be    = r_be;

    // covers the cycle before the controller leaves idle
    assign o_busy = i_ctrl_busy | r_rd | r_wr;

endmodule

`default_nettype wire

/* cache/dcache_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module dcache_array (
    input  wire                     CLK,
    input  wire                     i_rrst_x,
    input  wire [`MEM_ADDR_W-1:0]   i_lookup_addr,
    input  wire mem_pkg::cache_wr_t i_cwr,
    output mem_pkg::line_u          o_line,
    output wire                     o_hit
);

    localparam int OFF_W = $clog2(`MEM_LINE_W/8);
    localparam int IDX_W = $clog2(`CACHE_LINES);
    localparam int TAG_W = `MEM_ADDR_W - IDX_W - OFF_W;

    mem_pkg::line_u          data_mem [`CACHE_LINES];
    logic [TAG_W-1:0]        tag_mem  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] r_valid;
    logic [IDX_W-1:0]        w_lk_idx;
    logic [TAG_W-1:0]        w_lk_tag;
    logic [IDX_W-1:0]        w_wr_idx;
    logic [TAG_W-1:0]        w_wr_tag;
    logic [IDX_W-1:0]        r_idx;
    logic [TAG_W-1:0]        r_tag;      // stored tag
    logic [TAG_W-1:0]        r_lk_tag;   // looked-up tag
    logic                    r_vbit;

    assign w_lk_idx = i_lookup_addr[OFF_W +: IDX_W];
    assign w_lk_tag = i_lookup_addr[`MEM_ADDR_W-1 -: TAG_W];
    assign w_wr_idx = i_cwr.addr[OFF_W +: IDX_W];
    assign w_wr_tag = i_cwr.addr[`MEM_ADDR_W-1 -: TAG_W];

    always_ff @(posedge CLK) begin
        if (i_cwr.we) begin
            data_mem[w_wr_idx] <= i_cwr.line;
            tag_mem[w_wr_idx]  <= w_wr_tag;
        end
        o_line   <= data_mem[w_lk_idx];   // synchronous read
        r_tag    <= tag_mem[w_lk_idx];
        r_lk_tag <= w_lk_tag;
        r_idx    <= w_lk_idx;
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_valid <= '0;
            r_vbit  <= 1'b0;
        end else begin
            if (i_cwr.we) begin
                r_valid[w_wr_idx] <= 1'b1;
            end
            r_vbit <= r_valid[w_lk_idx];
        end
    end

    assign o_hit = r_vbit & (r_tag == r_lk_tag);

    a_hit_valid: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        o_hit |-> r_valid[r_idx]);

endmodule

`default_nettype wire

/* cache/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module dcache_ctrl (
    input  wire                     CLK,
    input  wire                     i_rrst_x,
    input  wire mem_pkg::core_req_t i_req,
    input  wire                     i_hit,
    input  wire mem_pkg::line_u     i_line,
    output wire [`MEM_ADDR_W-1:0]   o_lookup_addr,
    output mem_pkg::cache_wr_t      o_cwr,
    input  wire                     i_mem_stall,
    input  wire mem_pkg::line_u     i_mem_line,
    output mem_pkg::mem_req_t       o_mem_req,
    output mem_pkg::line_u          o_rdata,
    output wire                     o_busy
);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_READ      = 3'd1;
    localparam logic [2:0] S_READ_MISS = 3'd2;
    localparam logic [2:0] S_WRITE     = 3'd3;
    localparam logic [2:0] S_WBUF_WAIT = 3'd4;

    logic [2:0]         r_state;
    logic [2:0]         w_next;
    mem_pkg::core_req_t r_req;        // request in service
    mem_pkg::core_req_t r_wbuf;       // one-entry write buffer
    logic               r_wbuf_full;
    logic               w_wbuf_we;
    logic               w_mem_rd;
    logic               w_mem_wr;
    logic               w_start;
    mem_pkg::core_req_t w_src;
    mem_pkg::line_u     w_merged;

    assign w_start  = (r_state == S_IDLE) & (i_req.rd | i_req.wr);
    assign w_src    = (r_state == S_IDLE) ? i_req : r_req;
    assign w_mem_wr = r_wbuf_full & ~i_mem_stall;   // drain whenever memory is free

    // store word into the looked-up line, byte by byte
    always_comb begin
        w_merged = i_line;
        for (int k = 0; k < `MEM_WORD_W/8; k++) begin
            if (r_req.be[k]) begin
                w_merged.bytes[{r_req.addr[3:2], 2'(k)}] = r_req.wdata[8*k +: 8];
            end
        end
    end

    always_comb begin
        w_next     = r_state;
        w_wbuf_we  = 1'b0;
        w_mem_rd   = 1'b0;
        o_cwr.we   = 1'b0;
        o_cwr.addr = r_req.addr;
        o_cwr.line = w_merged;
        case (r_state)
            S_IDLE: begin
                if (i_req.wr) begin
                    if (!r_wbuf_full) begin
                        w_wbuf_we = 1'b1;
                        w_next    = S_WRITE;
                    end else begin
                        w_next = S_WBUF_WAIT;
                    end
                end else if (i_req.rd) begin
                    w_next = S_READ;
                end
            end
            S_READ: begin
                if (i_hit) begin
                    w_next = S_IDLE;
                end else if (!r_wbuf_full && !i_mem_stall) begin
                    w_mem_rd = 1'b1;   // pending store has gone out first
                    w_next   = S_READ_MISS;
                end
            end
            S_READ_MISS: begin
                if (!i_mem_stall) begin
                    o_cwr.we   = 1'b1;   // fill
                    o_cwr.line = i_mem_line;
                    w_next     = S_IDLE;
                end
            end
            S_WRITE: begin
                o_cwr.we = i_hit;   // no allocate on miss
                w_next   = S_IDLE;
            end
            S_WBUF_WAIT: begin
                if (!r_wbuf_full) begin
                    w_wbuf_we = 1'b1;
                    w_next    = S_WRITE;
                end
            end
            default: w_next = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_state     <= S_IDLE;
            r_wbuf_full <= 1'b0;
        end else begin
            r_state <= w_next;
            if (w_wbuf_we) begin
                r_wbuf_full <= 1'b1;
            end else if (w_mem_wr) begin
                r_wbuf_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (w_start) begin
            r_req <= i_req;
        end
        if (w_wbuf_we) begin
            r_wbuf <= w_src;
        end
        if (r_state == S_READ && i_hit) begin
            o_rdata <= i_line;
        end else if (r_state == S_READ_MISS && !i_mem_stall) begin
            o_rdata <= i_mem_line;
        end
    end

    always_comb begin
        o_mem_req.rd    = w_mem_rd;
        o_mem_req.wr    = w_mem_wr;
        o_mem_req.addr  = w_mem_rd ? r_req.addr : r_wbuf.addr;
        o_mem_req.wdata = r_wbuf.wdata;
        o_mem_req.be    = r_wbuf.be;
    end

    // array sees the new address while the request strobe is up
    assign o_lookup_addr = (r_state == S_IDLE) ? i_req.addr : r_req.addr;
    assign o_busy        = (r_state != S_IDLE);

    // no store slips into the buffer while a line fill is outstanding
    a_rd_after_drain: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        (r_state == S_READ_MISS) |-> !r_wbuf_full);

    // memory stalls after every access, so strobes never come back to back
    a_strobe_no_stall: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        (o_mem_req.rd || o_mem_req.wr) |=> !(o_mem_req.rd || o_mem_req.wr));

endmodule

`default_nettype wire

/* logic/backing_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module backing_mem (
    input  wire                     CLK,
    input  wire                     i_rrst_x,
    input  wire mem_pkg::mem_req_t  i_req,
    output wire                     o_stall,
    output mem_pkg::line_u          o_line
);

    localparam int OFF_W = $clog2(`MEM_LINE_W/8);
    localparam int IDX_W = $clog2(`BACK_DEPTH_LINES);
    localparam int CNT_W = $clog2(`BACK_LAT + 1);

    mem_pkg::line_u   mem [`BACK_DEPTH_LINES];
    logic [CNT_W-1:0] r_cnt;
    logic [IDX_W-1:0] w_idx;
    logic [OFF_W-3:0] w_lane;

    assign w_idx   = i_req.addr[OFF_W +: IDX_W];
    assign w_lane  = i_req.addr[OFF_W-1:2];   // word within the line
    assign o_stall = (r_cnt != '0);

    initial begin
        for (int i = 0; i < `BACK_DEPTH_LINES; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge CLK) begin
        if (i_req.wr) begin
            for (int k = 0; k < `MEM_WORD_W/8; k++) begin
                if (i_req.be[k]) begin
                    mem[w_idx].words[w_lane][8*k +: 8] <= i_req.wdata[8*k +: 8];
                end
            end
        end
        if (i_req.rd) begin
            o_line <= mem[w_idx];   // held until the next read
        end
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_cnt <= '0;
        end else if (i_req.rd | i_req.wr) begin
            r_cnt <= CNT_W'(`BACK_LAT);
        end else if (o_stall) begin
            r_cnt <= r_cnt - 1'b1;
        end
    end

    a_no_strobe_busy: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        o_stall |-> !(i_req.rd || i_req.wr));

endmodule

`default_nettype wire

/* logic/dram_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module dram_cache_top (
    input  wire                     CLK,
    input  wire                     i_rrst_x,
    input  wire                     i_rd_en,
    input  wire                     i_wr_en,
    input  wire [`MEM_ADDR_W-1:0]   i_addr,
    input  wire [`MEM_WORD_W-1:0]   i_wdata,
    input  wire mem_pkg::acc_size_e i_size,
    output wire                     o_busy,
    output wire mem_pkg::line_u     o_rdata
);

    mem_pkg::core_req_t     w_req;
    mem_pkg::cache_wr_t     w_cwr;
    mem_pkg::mem_req_t      w_mem_req;
    mem_pkg::line_u         w_cache_line;
    mem_pkg::line_u         w_mem_line;
    logic [`MEM_ADDR_W-1:0] w_lookup_addr;
    logic                   w_hit;
    logic                   w_ctrl_busy;
    logic                   w_mem_stall;

    mem_req_front u_front (
        .CLK         (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_rd_en     (i_rd_en),
        .i_wr_en     (i_wr_en),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .i_size      (i_size),
        .i_ctrl_busy (w_ctrl_busy),
        .o_req       (w_req),
        .o_busy      (o_busy)
    );

    dcache_ctrl u_ctrl (
        .CLK           (CLK),
        .i_rrst_x      (i_rrst_x),
        .i_req         (w_req),
        .i_hit         (w_hit),
        .i_line        (w_cache_line),
        .o_lookup_addr (w_lookup_addr),
        .o_cwr         (w_cwr),
        .i_mem_stall   (w_mem_stall),
        .i_mem_line    (w_mem_line),
        .o_mem_req     (w_mem_req),
        .o_rdata       (o_rdata),
        .o_busy        (w_ctrl_busy)
    );

    dcache_array u_array (
        .CLK           (CLK),
        .i_rrst_x      (i_rrst_x),
        .i_lookup_addr (w_lookup_addr),
        .i_cwr         (w_cwr),
        .o_line        (w_cache_line),
        .o_hit         (w_hit)
    );

    backing_mem u_mem (
        .CLK      (CLK),
        .i_rrst_x (i_rrst_x),
        .i_req    (w_mem_req),
        .o_stall  (w_mem_stall),
        .o_line   (w_mem_line)
    );

endmodule

`default_nettype wire

/* bench/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module tb_checker #(
    parameter int NAME_W = 128
) (
    input  wire                   CLK,
    input  wire                   i_rrst_x,
    input  wire                   i_rd_en,
    input  wire                   i_busy,
    input  wire mem_pkg::line_u   i_rdata,
    input  wire [`MEM_LINE_W-1:0] i_exp_line,
    input  wire [NAME_W-1:0]      i_exp_name,
    output logic [31:0]           o_pass_cnt,
    output logic [31:0]           o_fail_cnt,
    output logic                  o_pending
);

    logic [`MEM_LINE_W-1:0] r_exp;
    logic [NAME_W-1:0]      r_name;
    logic                   r_busy_q;
    logic [`MEM_LINE_W-1:0] w_act;

    assign w_act = i_rdata;

    // sampled mid-cycle, busy and rdata change just after the rising edge
    always @(negedge CLK) begin
        if (!i_rrst_x) begin
            o_pass_cnt <= '0;
            o_fail_cnt <= '0;
            o_pending  <= 1'b0;
            r_busy_q   <= 1'b0;
        end else begin
            r_busy_q <= i_busy;
            if (o_pending && r_busy_q && !i_busy) begin   // read just ended
                if (w_act === r_exp) begin
                    $display("[PASS] %0s", r_name);
                    o_pass_cnt <= o_pass_cnt + 32'd1;
                end else begin
                    $display("[FAIL] %0s expected %h actual %h", r_name, r_exp, w_act);
                    o_fail_cnt <= o_fail_cnt + 32'd1;
                end
                o_pending <= 1'b0;
            end
            if (i_rd_en && !i_busy) begin   // read accepted this cycle
                r_exp     <= i_exp_line;
                r_name    <= i_exp_name;
                o_pending <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module tb_top;

    localparam int NAME_W  = 8*16;
    localparam int TIMEOUT = 200;   // cycles allowed per wait

    logic                   CLK;
    logic                   rrst_x;
    logic                   rd_en;
    logic                   wr_en;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_WORD_W-1:0] wdata;
    mem_pkg::acc_size_e     size;
    logic                   busy;
    mem_pkg::line_u         rdata;
    logic [`MEM_LINE_W-1:0] exp_line;
    logic [NAME_W-1:0]      exp_name;
    logic [31:0]            pass_cnt;
    logic [31:0]            fail_cnt;
    logic                   pending;
    logic [31:0]            lfsr;
    logic [7:0]             xor_of [logic [31:0]];   // mask last written per byte address
    bit                     aborted;
    int                     fd;

    dram_cache_top u_dram_cache_top (
        .CLK      (CLK),
        .i_rrst_x (rrst_x),
        .i_rd_en  (rd_en),
        .i_wr_en  (wr_en),
        .i_addr   (addr),
        .i_wdata  (wdata),
        .i_size   (size),
        .o_busy   (busy),
        .o_rdata  (rdata)
    );

    tb_checker #(.NAME_W(NAME_W)) u_checker (
        .CLK        (CLK),
        .i_rrst_x   (rrst_x),
        .i_rd_en    (rd_en),
        .i_busy     (busy),
        .i_rdata    (rdata),
        .i_exp_line (exp_line),
        .i_exp_name (exp_name),
        .o_pass_cnt (pass_cnt),
        .o_fail_cnt (fail_cnt),
        .o_pending  (pending)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task draw_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // bytes a store of this size touches
    task note_written(input logic [31:0] a, input logic [1:0] sz, input logic [7:0] b);
        logic [31:0] first;
        int          n;
        case (sz)
            2'd0: begin
                first = a;
                n     = 1;
            end
            2'd1: begin
                first = {a[31:1], 1'b0};
                n     = 2;
            end
            default: begin
                first = {a[31:2], 2'b00};
                n     = 4;
            end
        endcase
        for (int k = 0; k < n; k++) begin
            xor_of[first + 32'(k)] = b;
        end
    endtask

    function automatic logic [`MEM_LINE_W-1:0] expected_line(input logic [31:0] a,
                                                             input logic [`MEM_LINE_W-1:0] gold);
        logic [`MEM_LINE_W-1:0] e;
        logic [31:0]            key;
        e = gold;
        for (int i = 0; i < `MEM_LINE_W/8; i++) begin
            key = {a[31:4], 4'h0} + 32'(i);
            if (xor_of.exists(key)) begin
                e[8*i +: 8] = e[8*i +: 8] ^ xor_of[key];
            end
        end
        return e;
    endfunction

    task wait_idle;
        int t;
        t = 0;
        while (busy && t < TIMEOUT) begin
            @(posedge CLK);
            #1;
            t++;
        end
        if (busy) begin
            $display("timed out after %0d cycles waiting for o_busy to fall", TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    task wait_checker;
        int t;
        t = 0;
        while (pending && t < TIMEOUT) begin
            @(posedge CLK);
            #1;
            t++;
        end
        if (pending) begin
            $display("timed out waiting for the checker to see the last read end");
            aborted = 1'b1;
        end
    endtask

    task issue_op(input logic [NAME_W-1:0] name, input int op, input int sz,
                  input logic [31:0] a, input logic [31:0] d,
                  input logic [`MEM_LINE_W-1:0] gold);
        logic [7:0] b;
        wait_idle;
        if (!aborted) begin
            addr     = a;
            size     = mem_pkg::acc_size_e'(sz[1:0]);
            exp_name = name;
            if (op == 1) begin
                draw_byte(b);
                wdata = d ^ {4{b}};
                note_written(a, sz[1:0], b);
                wr_en = 1'b1;
            end else begin
                exp_line = expected_line(a, gold);
                rd_en    = 1'b1;
            end
            @(posedge CLK);
            #1;
            rd_en = 1'b0;
            wr_en = 1'b0;
        end
    endtask

    initial begin
        logic [8*128-1:0]       text;
        logic [NAME_W-1:0]      name;
        logic [31:0]            a;
        logic [31:0]            d;
        logic [`MEM_LINE_W-1:0] gold;
        int                     op;
        int                     sz;
        int                     n;
        int                     fields;
        rrst_x   = 1'b0;
        rd_en    = 1'b0;
        wr_en    = 1'b0;
        addr     = '0;
        wdata    = '0;
        size     = mem_pkg::SZ_WORD;
        exp_line = '0;
        exp_name = '0;
        lfsr     = 32'h7c57c5ac;
        aborted  = 1'b0;
        repeat (2) @(posedge CLK);
        #1;
        rrst_x = 1'b1;

        fd = $fopen("bench/mem_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/mem_golden.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && !$feof(fd)) begin
                n      = $fgets(text, fd);
                fields = 0;
                if (n > 0) begin
                    fields = $sscanf(text, "%s %d %d %h %h %h", name, op, sz, a, d, gold);
                end
                // comment and blank lines do not scan six fields
                if (fields == 6) begin
                    issue_op(name, op, sz, a, d, gold);
                end
            end
            $fclose(fd);
        end
        if (!aborted) begin
            wait_idle;
        end
        if (!aborted) begin
            wait_checker;
        end

        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (!aborted && fail_cnt == 0 && pass_cnt != 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/mem_pkg.sv
logic/mem_req_front.sv
cache/dcache_array.sv
cache/dcache_ctrl.sv
logic/backing_mem.sv
logic/dram_cache_top.sv
bench/tb_checker.sv
bench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it and scan the log for the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -Mdir obj_dir -f list.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -F -q 'All tests passed!' sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* bench/mem_golden.txt */
# columns: name op(0 read, 1 write) size(0 byte, 1 half, 2 word) addr wdata expected_line
# fields after size are hex; the expected line is ignored for writes
rd_reset_zero 0 2 00000100 00000000 00000000000000000000000000000000
wr_word_lane1 1 2 00000104 11223344 00000000000000000000000000000000
rd_word_lane1 0 2 00000100 00000000 00000000000000001122334400000000
wr_byte_b11 1 0 0000010b 000000a5 00000000000000000000000000000000
wr_half_b14 1 1 0000010e 0000beef 00000000000000000000000000000000
rd_byte_half 0 2 00000100 00000000 beef0000a50000001122334400000000
wr_nocache 1 2 00000308 cafef00d 00000000000000000000000000000000
rd_from_mem 0 2 00000300 00000000 00000000cafef00d0000000000000000
rd_again_hit 0 2 00000300 00000000 00000000cafef00d0000000000000000
wr_tag_a 1 2 00000000 0a0b0c0d 00000000000000000000000000000000
wr_tag_b 1 2 0000040c 5a5a1234 00000000000000000000000000000000
rd_tag_a 0 2 00000000 00000000 0000000000000000000000000a0b0c0d
rd_tag_b 0 2 00000400 00000000 5a5a1234000000000000000000000000
rd_tag_a_again 0 2 00000000 00000000 0000000000000000000000000a0b0c0d
wr_burst_byte 1 0 00000001 00000077 00000000000000000000000000000000
wr_burst_half 1 1 00000006 00009988 00000000000000000000000000000000
wr_burst_word 1 2 00000008 01020304 00000000000000000000000000000000
rd_burst 0 2 00000000 00000000 0000000001020304998800000a0b770d
